// ==== common/copper_isa_pkg.sv ====
package copper_isa_pkg;

    // width of the argument field in the even word
    localparam int COP_ARG_W = 14;

    // one word of copper memory, as the host writes it
    typedef logic [15:0] cop_word_t;

    typedef enum logic [1:0] {
        OP_END   = 2'd0,
        OP_WAITV = 2'd1,
        OP_MOVE  = 2'd2,
        OP_JUMP  = 2'd3
    } cop_op_t;

    // even word in the upper half, odd word in the lower half
    typedef struct packed {
        cop_op_t                op;
        logic [COP_ARG_W-1:0]   arg;
        cop_word_t              data;
    } cop_instr_t;

    // an END pair, the contents of memory before the host loads anything
    localparam cop_word_t COP_END_EVEN = 16'h0000;
    localparam cop_word_t COP_END_ODD  = 16'h0003;

endpackage

// ==== common/video_bus_pkg.sv ====
package video_bus_pkg;

    localparam int LINE_W = 10;

    // current raster line from the video timing generator
    typedef logic [LINE_W-1:0] line_t;

    // host word write, addr bit 0 picks the even or odd half
    typedef struct packed {
        logic [15:0]    addr;
        logic [15:0]    data;
    } host_wr_t;

    // write into the video register file
    typedef struct packed {
        logic [7:0]     num;
        logic [15:0]    data;
    } reg_wr_t;

endpackage

// ==== copper/coppermem.sv ====
`timescale 1ns/1ps

module coppermem #(
    parameter int AWIDTH  = 8,
    parameter int ODDWORD = 0
) (
    input  logic                        clk,
    input  logic [AWIDTH-1:0]           rd_address_i,
    input  logic                        wr_en_i,
    input  logic [AWIDTH-1:0]           wr_address_i,
    input  copper_isa_pkg::cop_word_t   wr_data_i,
    output copper_isa_pkg::cop_word_t   rd_data_o
);

    import copper_isa_pkg::*;

    // one half of the copper program, the other half sits beside it
    cop_word_t bram [0:2**AWIDTH-1];

    // every pair starts out as END so an empty copper halts right away
    initial begin
        for (int i = 0; i < 2**AWIDTH; i++) begin
            bram[i] = (ODDWORD != 0) ? COP_END_ODD : COP_END_EVEN;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            bram[wr_address_i] <= wr_data_i;
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rd_data_o <= bram[rd_address_i];
    end

endmodule

// ==== copper/copper_exec.sv ====
`timescale 1ns/1ps

module copper_exec #(
    parameter int AWIDTH = 8
) (
    input  logic                                clk,
    input  logic                                arst_n_i,
    input  logic                                frame_start_i,
    input  video_bus_pkg::line_t                line_i,
    input  copper_isa_pkg::cop_word_t [1:0]     rd_data_i,
    output logic [AWIDTH-1:0]                   rd_addr_o,
    output video_bus_pkg::reg_wr_t              reg_wr_o,
    output logic                                reg_wr_stb_o
);

    import copper_isa_pkg::*;

    typedef enum logic [1:0] {
        ST_HALT,
        ST_FETCH,
        ST_EXEC
    } state_t;

    state_t             state;
    logic [AWIDTH-1:0]  pc;
    cop_instr_t         instr;
    logic               line_reached;
    logic               move_go;

    // even half carries opcode and argument, odd half the data
    assign instr = cop_instr_t'({rd_data_i[0], rd_data_i[1]});

    assign line_reached = COP_ARG_W'(line_i) >= instr.arg;

    // a frame start wins over whatever the current instruction does
    assign move_go = (state == ST_EXEC) && (instr.op == OP_MOVE) && !frame_start_i;

    // memory read address follows pc, data is valid one cycle after fetch
    assign rd_addr_o = pc;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state        <= ST_HALT;
            pc           <= '0;
            reg_wr_stb_o <= 1'b0;
        end else begin
            reg_wr_stb_o <= move_go;
            if (frame_start_i) begin
                pc    <= '0;
                state <= ST_FETCH;
            end else begin
                case (state)
                    ST_HALT: begin
                        state <= ST_HALT;
                    end
                    ST_FETCH: begin
                        state <= ST_EXEC;
                    end
                    ST_EXEC: begin
                        case (instr.op)
                            OP_END: begin
                                state <= ST_HALT;
                            end
                            OP_WAITV: begin
                                // hold in execute until the beam gets there
                                if (line_reached) begin
                                    pc    <= pc + 1'b1;
                                    state <= ST_FETCH;
                                end
                            end
                            OP_MOVE: begin
                                pc    <= pc + 1'b1;
                                state <= ST_FETCH;
                            end
                            OP_JUMP: begin
                                pc    <= instr.arg[AWIDTH-1:0];
                                state <= ST_FETCH;
                            end
                            default: begin
                                state <= ST_HALT;
                            end
                        endcase
                    end
                    default: begin
                        state <= ST_HALT;
                    end
                endcase
            end
        end
    end

    // register write payload, qualified by reg_wr_stb_o
    always_ff @(posedge clk) begin
        if (move_go) begin
            reg_wr_o.num  <= instr.arg[7:0];
            reg_wr_o.data <= instr.data;
        end
    end

endmodule

// ==== hw/cop_host_port.sv ====
`timescale 1ns/1ps

module cop_host_port #(
    parameter int AWIDTH = 8
) (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  video_bus_pkg::host_wr_t     host_wr_i,
    input  logic                        host_wr_stb_i,
    output logic [1:0]                  wr_en_o,
    output logic [AWIDTH-1:0]           wr_addr_o,
    output copper_isa_pkg::cop_word_t   wr_data_o
);

    logic odd_sel;

    assign odd_sel = host_wr_i.addr[0];

    // one enable per half, at most one high per cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_en_o <= 2'b00;
        end else begin
            wr_en_o[0] <= host_wr_stb_i && !odd_sel;
            wr_en_o[1] <= host_wr_stb_i && odd_sel;
        end
    end

    // word address above bit 0 is the pair index, shared by both halves
    always_ff @(posedge clk) begin
        if (host_wr_stb_i) begin
            wr_addr_o <= host_wr_i.addr[AWIDTH:1];
            wr_data_o <= host_wr_i.data;
        end
    end

endmodule

// ==== hw/copper_top.sv ====
`timescale 1ns/1ps

module copper_top #(
    parameter int AWIDTH = 8
) (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  video_bus_pkg::host_wr_t     host_wr_i,
    input  logic                        host_wr_stb_i,
    input  logic                        frame_start_i,
    input  video_bus_pkg::line_t        line_i,
    output video_bus_pkg::reg_wr_t      reg_wr_o,
    output logic                        reg_wr_stb_o
);

    import copper_isa_pkg::*;

    logic [1:0]         wr_en;
    logic [AWIDTH-1:0]  wr_addr;
    cop_word_t          wr_data;
    logic [AWIDTH-1:0]  rd_addr;
    cop_word_t [1:0]    rd_data;

    cop_host_port #(
        .AWIDTH(AWIDTH)
    ) cop_host_port_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .host_wr_i     (host_wr_i),
        .host_wr_stb_i (host_wr_stb_i),
        .wr_en_o       (wr_en),
        .wr_addr_o     (wr_addr),
        .wr_data_o     (wr_data)
    );

    // index 0 is the even half, index 1 the odd half
    for (genvar i = 0; i < 2; i++) begin : g_half
        coppermem #(
            .AWIDTH  (AWIDTH),
            .ODDWORD (i)
        ) coppermem_inst (
            .clk          (clk),
            .rd_address_i (rd_addr),
            .wr_en_i      (wr_en[i]),
            .wr_address_i (wr_addr),
            .wr_data_i    (wr_data),
            .rd_data_o    (rd_data[i])
        );
    end

    copper_exec #(
        .AWIDTH(AWIDTH)
    ) copper_exec_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .frame_start_i (frame_start_i),
        .line_i        (line_i),
        .rd_data_i     (rd_data),
        .rd_addr_o     (rd_addr),
        .reg_wr_o      (reg_wr_o),
        .reg_wr_stb_o  (reg_wr_stb_o)
    );

endmodule

// ==== tests/copper_asserts.sv ====
`timescale 1ns/1ps

module copper_asserts (
    input  logic    clk,
    input  logic    arst_n_i,
    input  logic    frame_start_i,
    input  logic    reg_wr_stb_o
);

    logic   frame_seen;
    int     fail_count = 0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            frame_seen <= 1'b0;
        end else if (frame_start_i) begin
            frame_seen <= 1'b1;
        end
    end

    // a MOVE takes two cycles, so strobes never touch
    strobe_single: assert property (@(posedge clk) disable iff (!arst_n_i)
        reg_wr_stb_o |=> !reg_wr_stb_o)
        else begin
            fail_count++;
            $error("reg_wr_stb_o high in two consecutive cycles");
        end

    // copper is halted until the first frame start
    quiet_until_frame: assert property (@(posedge clk) disable iff (!arst_n_i)
        !frame_seen |-> !reg_wr_stb_o)
        else begin
            fail_count++;
            $error("reg_wr_stb_o high before the first frame_start_i");
        end

endmodule

bind copper_exec copper_asserts copper_asserts_inst (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .frame_start_i (frame_start_i),
    .reg_wr_stb_o  (reg_wr_stb_o)
);

// ==== tests/copper_tb.sv ====
`timescale 1ns/1ps

module copper_tb;

    import copper_isa_pkg::*;
    import video_bus_pkg::*;

    localparam int AWIDTH = 8;
    localparam int DEPTH  = 2**AWIDTH;

    // one expected register write and the lowest line it may appear on
    typedef struct packed {
        reg_wr_t    wr;
        line_t      min_line;
    } exp_wr_t;

    logic           clk;
    logic           arst_n_i;
    host_wr_t       host_wr_i;
    logic           host_wr_stb_i;
    logic           frame_start_i;
    line_t          line_i;
    reg_wr_t        reg_wr_o;
    logic           reg_wr_stb_o;

    // even and odd words of the program as the host has loaded it
    logic [15:0]    prog_even [0:DEPTH-1];
    logic [15:0]    prog_odd  [0:DEPTH-1];
    exp_wr_t        exp_q [$];

    logic [31:0]    rand_state;
    int             line_div;
    int             line_cnt;
    line_t          line_seen;
    int             value_errs;
    int             other_errs;
    int             assert_errs;

    copper_top #(
        .AWIDTH(AWIDTH)
    ) copper_top_inst (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .host_wr_i     (host_wr_i),
        .host_wr_stb_i (host_wr_stb_i),
        .frame_start_i (frame_start_i),
        .line_i        (line_i),
        .reg_wr_o      (reg_wr_o),
        .reg_wr_stb_o  (reg_wr_stb_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'((next_rand() >> 8) % 32'(hi - lo + 1));
    endfunction

    function automatic logic [15:0] move_even(input logic [7:0] num);
        return {2'b10, 6'(next_rand() >> 20), num};
    endfunction

    // line the copper sees at the edge that launches a strobe
    always @(posedge clk) begin
        line_seen <= line_i;
    end

    always @(negedge clk) begin
        exp_wr_t head;
        if (arst_n_i && reg_wr_stb_o) begin
            assert (exp_q.size() > 0) else begin
                other_errs++;
                $display("copper wrote register %h = %h that the program never writes",
                         reg_wr_o.num, reg_wr_o.data);
            end
            if (exp_q.size() > 0) begin
                head = exp_q.pop_front();
                assert (reg_wr_o == head.wr) else begin
                    value_errs++;
                    $display("Fail reg_wr_o expected %h got %h", head.wr, reg_wr_o);
                end
                assert (line_seen >= head.min_line) else begin
                    value_errs++;
                    $display("Fail line_i expected at least %h got %h",
                             head.min_line, line_seen);
                end
            end
        end
    end

    // strobes drop and the raster line may advance on each falling edge
    task automatic tick();
        @(negedge clk);
        host_wr_stb_i = 1'b0;
        frame_start_i = 1'b0;
        if (line_div > 0) begin
            line_cnt++;
            if (line_cnt >= line_div) begin
                line_cnt = 0;
                line_i   = line_i + 10'd1;
            end
        end
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) tick();
    endtask

    task automatic host_write(input int pair, input bit odd, input logic [15:0] data);
        tick();
        host_wr_i.addr = 16'(pair * 2 + int'(odd));
        host_wr_i.data = data;
        host_wr_stb_i  = 1'b1;
        if (odd) begin
            prog_odd[pair] = data;
        end else begin
            prog_even[pair] = data;
        end
    endtask

    task automatic load_pair(input int pair, input logic [15:0] even, input logic [15:0] odd);
        host_write(pair, 1'b0, even);
        host_write(pair, 1'b1, odd);
    endtask

    // walk the loaded program from pair 0 and queue the writes it makes
    task automatic build_expected();
        int             pc;
        int             steps;
        bit             done;
        line_t          line_floor;
        logic [15:0]    ev;
        exp_wr_t        e;
        exp_q.delete();
        pc         = 0;
        steps      = 0;
        done       = 1'b0;
        line_floor = '0;
        while (!done && steps < 4 * DEPTH) begin
            ev = prog_even[pc];
            steps++;
            case (ev[15:14])
                2'd0: done = 1'b1;
                2'd1: begin
                    if (ev[9:0] > line_floor) begin
                        line_floor = ev[9:0];
                    end
                    pc = (pc + 1) % DEPTH;
                end
                2'd2: begin
                    e.wr.num   = ev[7:0];
                    e.wr.data  = prog_odd[pc];
                    e.min_line = line_floor;
                    exp_q.push_back(e);
                    pc = (pc + 1) % DEPTH;
                end
                default: pc = int'(ev[AWIDTH-1:0]);
            endcase
        end
    endtask

    task automatic start_frame();
        tick();
        frame_start_i = 1'b1;
        line_i        = '0;
        line_cnt      = 0;
    endtask

    task automatic wait_writes(input int left, input int limit);
        int n;
        n = 0;
        while (exp_q.size() > left && n < limit) begin
            tick();
            n++;
        end
        assert (exp_q.size() <= left) else begin
            other_errs++;
            $display("copper produced too few register writes");
        end
    endtask

    task automatic run_program(input int limit);
        idle(2);
        build_expected();
        start_frame();
        wait_writes(0, limit);
        // nothing may follow the END
        idle(50);
    endtask

    initial begin
        int n;
        int target;
        rand_state    = 32'hf997_1f66;
        arst_n_i      = 1'b0;
        host_wr_i     = '0;
        host_wr_stb_i = 1'b0;
        frame_start_i = 1'b0;
        line_i        = '0;
        line_div      = 0;
        line_cnt      = 0;
        value_errs    = 0;
        other_errs    = 0;
        assert_errs   = 0;
        for (int i = 0; i < DEPTH; i++) begin
            prog_even[i] = 16'h0000;
            prog_odd[i]  = 16'h0003;
        end
        repeat (8) @(negedge clk);
        arst_n_i = 1'b1;
        idle(4);

        // empty memory decodes as END everywhere
        run_program(50);

        n = rand_range(3, 12);
        for (int i = 0; i < n; i++) begin
            load_pair(i, move_even(8'(next_rand() >> 8)), 16'(next_rand() >> 8));
        end
        load_pair(n, 16'h0000, 16'(next_rand() >> 8));
        run_program(200);

        // WAITVs mixed in while the beam crawls
        line_div = 3;
        n = rand_range(6, 14);
        for (int i = 0; i < n; i++) begin
            if (rand_range(0, 2) == 0) begin
                load_pair(i, {2'b01, 4'b0, 10'(rand_range(0, 60))}, 16'(next_rand() >> 8));
            end else begin
                load_pair(i, move_even(8'(next_rand() >> 8)), 16'(next_rand() >> 8));
            end
        end
        load_pair(n, 16'h0000, 16'(next_rand() >> 8));
        run_program(3000);
        line_div = 0;

        // JUMP over a block of MOVEs
        target = 2 + rand_range(1, 4);
        load_pair(0, move_even(8'(next_rand() >> 8)), 16'(next_rand() >> 8));
        load_pair(1, {2'b11, 14'(target)}, 16'(next_rand() >> 8));
        for (int i = 2; i < target + 2; i++) begin
            load_pair(i, move_even(8'(next_rand() >> 8)), 16'(next_rand() >> 8));
        end
        load_pair(target + 2, 16'h0000, 16'(next_rand() >> 8));
        run_program(200);

        // only the odd word of pair 0 changes
        host_write(0, 1'b1, 16'(next_rand() >> 8));
        run_program(200);

        // frame start in the middle of a long WAITV
        load_pair(0, move_even(8'(next_rand() >> 8)), 16'(next_rand() >> 8));
        load_pair(1, {2'b01, 14'd200}, 16'(next_rand() >> 8));
        load_pair(2, move_even(8'(next_rand() >> 8)), 16'(next_rand() >> 8));
        load_pair(3, 16'h0000, 16'(next_rand() >> 8));
        idle(2);
        build_expected();
        start_frame();
        wait_writes(1, 100);
        idle(20);
        build_expected();
        start_frame();
        line_div = 1;
        wait_writes(0, 1000);
        line_div = 0;
        idle(30);

        assert_errs = copper_top_inst.copper_exec_inst.copper_asserts_inst.fail_count;
        $display("errors: %0d value mismatches, %0d other failures, %0d assertion failures",
                 value_errs, other_errs, assert_errs);
        if (value_errs + other_errs + assert_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
common/copper_isa_pkg.sv
common/video_bus_pkg.sv
copper/coppermem.sv
copper/copper_exec.sv
hw/cop_host_port.sv
hw/copper_top.sv
tests/copper_asserts.sv
tests/copper_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the copper testbench with Verilator, run it, and judge the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module copper_tb -f vlog.f -o copper_sim \
    && ./obj_dir/copper_sim +verilator+error+limit+100 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TEST RESULT: PASS" sim.log && exit 0 || exit 1
